//--- vlog.f
thumb_ctrl_pkg.sv
inst_fields_if.sv
ctrl_word_if.sv
seq_ctrl_if.sv
inst_class_decode.sv
alu_op_decode.sv
reg_list_sequencer.sv
ctrl_output_stage.sv
thumb_ctrl_top.sv
thumb_ctrl_properties.sv
thumb_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and searches the log for the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=thumb_ctrl_sim

verilator --binary --timing --assert -Wno-fatal \
    --top-module thumb_ctrl_tb -f vlog.f --Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation did not pass"
exit 1

//--- thumb_ctrl_tb.sv
`default_nettype none

module thumb_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import thumb_ctrl_pkg::*;

    localparam int unsigned CLK_PERIOD  = 8;
    localparam int unsigned SEED        = 66;
    localparam int unsigned NUM_RANDOM  = 120;
    localparam int unsigned MAX_INSTR   = 200;
    localparam int unsigned MAX_CYCLES  = 20;
    localparam int unsigned WATCHDOG_NS = MAX_INSTR * MAX_CYCLES * CLK_PERIOD;

    logic        clk_i;
    logic        reset_i;
    logic        is_valid_i;
    logic [15:0] instruction_i;
    logic        is_valid_o;
    logic        update_flag_o;
    logic        mem_write_en_o;
    logic        mem_read_en_o;
    logic        reg_write_en_o;
    logic        reg_data_from_mem_o;
    alu_src_e    alu_a_sel_o;
    alu_src_e    alu_b_sel_o;
    alu_op_e     alu_op_o;
    logic        stall_o;
    logic        reg_addr_2_from_ctrl_o;
    logic        reg_dest_from_ctrl_o;
    logic        reg_3_select_o;
    logic [31:0] accumulator_imm_o;
    logic [3:0]  reg_file_addr_o;

    // expected outputs that the reference model fills in
    logic        exp_valid;
    logic        exp_flag;
    logic        exp_mem_wr;
    logic        exp_mem_rd;
    logic        exp_reg_wr;
    logic        exp_from_mem;
    alu_src_e    exp_a_sel;
    alu_src_e    exp_b_sel;
    alu_op_e     exp_op;
    logic        exp_stall;
    logic        exp_addr_2;
    logic        exp_dest;
    logic        exp_reg_3;
    logic [31:0] exp_acc;
    logic [3:0]  exp_addr;
    string       test_name;

    thumb_ctrl_top thumb_ctrl_top_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout, the tests did not finish in %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

    function automatic inst_class_e classify(input logic [15:0] instr, input logic valid);
        if (!valid) begin
            return INVALID;
        end
        casez (instr)
            16'b00??_????_????_????: return SHIFT_IMM;
            16'b0100_00??_????_????: return DATA_PROC;
            16'b0101_????_????_????: return LS_REG;
            16'b011?_????_????_????: return LS_IMM;
            16'b100?_????_????_????: return LS_IMM;
            16'b1011_010?_????_????: return PUSH;
            16'b1100_0???_????_????: return STM;
            default: return INVALID;
        endcase
    endfunction

    // push carries the link register in bit 8 of the encoding
    function automatic logic [15:0] list_of(input logic [15:0] instr, input inst_class_e cls);
        if (cls == PUSH) begin
            return {1'b0, instr[8], 6'b0, instr[7:0]};
        end
        return {8'h00, instr[7:0]};
    endfunction

    function automatic int count_regs(input logic [15:0] list);
        int n;
        n = 0;
        for (int i = 0; i < 16; i++) begin
            n += int'(list[i]);
        end
        return n;
    endfunction

    // register number of the k-th listed register counting from r0 upward
    function automatic logic [3:0] nth_reg(input logic [15:0] list, input int k);
        int seen;
        seen = 0;
        for (int i = 0; i < 16; i++) begin
            if (list[i]) begin
                if (seen == k) begin
                    return 4'(i);
                end
                seen++;
            end
        end
        return 4'd0;
    endfunction

    function automatic alu_op_e dp_op_of(input logic [3:0] code);
        case (code)
            4'd0: return AND;
            4'd1: return XOR;
            4'd2: return LSL;
            4'd3: return LSR;
            4'd4: return ASR;
            4'd5: return ADC;
            4'd6: return SBC;
            4'd7: return ROR;
            4'd8: return AND;
            4'd9: return SUB;
            4'd10: return SUB;
            4'd11: return ADD;
            4'd12: return OR;
            4'd13: return MUL;
            4'd14: return BIC;
            default: return MVN;
        endcase
    endfunction

    // expected outputs of step k of the instruction where single-cycle groups only have step 0
    task automatic predict(input logic [15:0] instr, input logic valid, input int k);
        inst_class_e cls;
        logic [15:0] list;
        logic [4:0]  sub;
        int          n;
        cls          = classify(instr, valid);
        sub          = instr[13:9];
        exp_valid    = (cls != INVALID);
        exp_flag     = 1'b0;
        exp_mem_wr   = 1'b0;
        exp_mem_rd   = 1'b0;
        exp_reg_wr   = 1'b0;
        exp_from_mem = 1'b0;
        exp_a_sel    = FROM_REG;
        exp_b_sel    = FROM_REG;
        exp_op       = ADD;
        exp_stall    = 1'b0;
        exp_addr_2   = 1'b0;
        exp_dest     = 1'b0;
        exp_reg_3    = 1'b0;
        exp_acc      = 32'd0;
        exp_addr     = 4'd0;
        case (cls)
            SHIFT_IMM: begin
                exp_flag   = 1'b1;
                exp_reg_wr = 1'b1;
                exp_b_sel  = FROM_IMM;
                case (sub[4:2])
                    3'b000: exp_op = LSL;
                    3'b001: exp_op = LSR;
                    3'b010: exp_op = ASR;
                    3'b011: begin
                        exp_op = sub[0] ? SUB : ADD;
                        if (!sub[1]) begin
                            exp_b_sel = FROM_REG;
                        end
                    end
                    3'b100: exp_a_sel = FROM_ZERO;
                    3'b101: begin
                        exp_op     = SUB;
                        exp_reg_wr = 1'b0;
                    end
                    3'b110: exp_op = ADD;
                    default: exp_op = SUB;
                endcase
            end
            DATA_PROC: begin
                exp_flag   = 1'b1;
                exp_op     = dp_op_of(instr[9:6]);
                exp_reg_wr = !(instr[9:6] inside {4'd8, 4'd10, 4'd11});
                if (instr[9:6] == 4'd9) begin
                    exp_a_sel = FROM_ZERO;
                end
            end
            LS_REG: begin
                exp_from_mem = 1'b1;
                exp_mem_rd   = instr[11] || (instr[10:9] == 2'b11);
                exp_reg_wr   = exp_mem_rd;
                exp_mem_wr   = !exp_mem_rd;
                exp_reg_3    = !exp_mem_rd;
            end
            LS_IMM: begin
                exp_from_mem = 1'b1;
                exp_b_sel    = FROM_IMM;
                exp_mem_rd   = instr[11];
                exp_reg_wr   = instr[11];
                exp_mem_wr   = !instr[11];
            end
            PUSH, STM: begin
                list      = list_of(instr, cls);
                n         = count_regs(list);
                exp_op    = (cls == PUSH) ? SUB : ADD;
                exp_b_sel = FROM_ACCUMULATOR;
                if (k < n) begin
                    exp_stall  = 1'b1;
                    exp_mem_wr = 1'b1;
                    exp_addr_2 = 1'b1;
                    exp_addr   = nth_reg(list, k);
                    exp_acc    = (cls == PUSH) ? 32'(4 * (n - k)) : 32'(4 * k);
                end else begin
                    exp_reg_wr = 1'b1;
                    exp_dest   = (cls == STM);
                    exp_addr   = (cls == PUSH) ? 4'd13 : {1'b0, instr[10:8]};
                    exp_acc    = 32'(4 * n);
                end
            end
            default: ;
        endcase
    endtask

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s %s expected %0h actual %0h", test_name, field, expected, actual);
            $display("Something failed");
            $fatal(1, "mismatch on %s", field);
        end
    endtask

    task automatic check_outputs();
        check_value("is_valid", 32'(exp_valid), 32'(is_valid_o));
        check_value("update_flag", 32'(exp_flag), 32'(update_flag_o));
        check_value("mem_write_en", 32'(exp_mem_wr), 32'(mem_write_en_o));
        check_value("mem_read_en", 32'(exp_mem_rd), 32'(mem_read_en_o));
        check_value("reg_write_en", 32'(exp_reg_wr), 32'(reg_write_en_o));
        check_value("reg_data_from_mem", 32'(exp_from_mem), 32'(reg_data_from_mem_o));
        check_value("alu_a_sel", 32'(exp_a_sel), 32'(alu_a_sel_o));
        check_value("alu_b_sel", 32'(exp_b_sel), 32'(alu_b_sel_o));
        check_value("alu_op", 32'(exp_op), 32'(alu_op_o));
        check_value("stall", 32'(exp_stall), 32'(stall_o));
        check_value("reg_addr_2_from_ctrl", 32'(exp_addr_2), 32'(reg_addr_2_from_ctrl_o));
        check_value("reg_dest_from_ctrl", 32'(exp_dest), 32'(reg_dest_from_ctrl_o));
        check_value("reg_3_select", 32'(exp_reg_3), 32'(reg_3_select_o));
        check_value("accumulator_imm", exp_acc, accumulator_imm_o);
        check_value("reg_file_addr", 32'(exp_addr), 32'(reg_file_addr_o));
    endtask

    // inputs stay put while the sequencer stalls and each step is checked mid-cycle
    task automatic run_instr(input string name, input logic [15:0] instr, input logic valid);
        inst_class_e cls;
        int          n;
        cls = classify(instr, valid);
        n   = 0;
        if ((cls == PUSH) || (cls == STM)) begin
            n = count_regs(list_of(instr, cls));
        end
        test_name = name;
        @(posedge clk_i);
        #1;
        instruction_i = instr;
        is_valid_i    = valid;
        for (int k = 0; k <= n; k++) begin
            if (k > 0) begin
                @(posedge clk_i);
                #1;
            end
            #2;
            predict(instr, valid, k);
            check_outputs();
        end
    endtask

    function automatic logic [15:0] random_instr();
        logic [15:0] r;
        r = 16'($urandom);
        case ($urandom_range(9, 0))
            0: r[15:14] = 2'b00;
            1: r[15:10] = 6'b010000;
            2: r[15:12] = 4'b0101;
            3: r[15:13] = 3'b011;
            4: r[15:13] = 3'b100;
            5: r[15:9] = 7'b1011010;
            6: r[15:11] = 5'b11000;
            // hi-register group and pop decode as invalid
            7: r[15:10] = 6'b010001;
            8: r[15:9] = 7'b1011110;
            default: ;
        endcase
        return r;
    endfunction

    initial begin
        void'($urandom(SEED));
        reset_i       = 1'b1;
        is_valid_i    = 1'b0;
        instruction_i = 16'h0000;
        repeat (10) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        for (int d = 0; d < 16; d++) begin
            run_instr("data_proc", {6'b010000, 4'(d), 6'b011010}, 1'b1);
        end
        for (int s = 0; s < 32; s++) begin
            run_instr("shift_imm", {2'b00, 5'(s), 9'h0b3}, 1'b1);
        end
        for (int m = 0; m < 8; m++) begin
            run_instr("ls_reg", {4'b0101, 3'(m), 9'h04c}, 1'b1);
        end
        for (int m = 0; m < 4; m++) begin
            run_instr("ls_imm_word_byte", {3'b011, 2'(m), 11'h1d4}, 1'b1);
            run_instr("ls_imm_half_sp", {3'b100, 2'(m), 11'h2e9}, 1'b1);
        end

        run_instr("stm_empty", {5'b11000, 3'd5, 8'h00}, 1'b1);
        run_instr("stm_full", {5'b11000, 3'd2, 8'hff}, 1'b1);
        run_instr("stm_random", {5'b11000, 3'd6, 8'($urandom)}, 1'b1);
        run_instr("push_empty", {7'b1011010, 9'h000}, 1'b1);
        run_instr("push_full", {7'b1011010, 9'h1ff}, 1'b1);
        run_instr("push_random", {7'b1011010, 9'($urandom)}, 1'b1);

        run_instr("valid_low", {5'b11000, 3'd1, 8'h3c}, 1'b0);
        run_instr("pop", 16'hbc0f, 1'b1);
        run_instr("hi_reg", 16'h4478, 1'b1);
        run_instr("long_branch", 16'hf000, 1'b1);
        run_instr("load_multiple", 16'hc90e, 1'b1);

        for (int t = 0; t < NUM_RANDOM; t++) begin
            run_instr("random", random_instr(), ($urandom_range(9, 0) != 0));
        end

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- thumb_ctrl_properties.sv
`default_nettype none

module thumb_ctrl_properties (
    input wire logic clk_i,
    input wire logic reset_i,
    input wire logic is_valid_i,
    input wire logic stall_i,
    input wire logic mem_write_en_i,
    input wire logic mem_read_en_i,
    input wire logic reg_write_en_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // number of consecutive stalled edges seen so far
    logic [4:0] stall_run;

    always_ff @(posedge clk_i) begin
        if (reset_i || !stall_i) begin
            stall_run <= '0;
        end else begin
            stall_run <= stall_run + 5'd1;
        end
    end

    assert property (@(posedge clk_i) reset_i |-> !stall_i)
        else $error("stall is high during reset");

    assert property (@(posedge clk_i) disable iff (reset_i)
        !(mem_write_en_i && mem_read_en_i))
        else $error("memory read and write enabled together");

    // a full list of sixteen registers is the longest possible stall
    assert property (@(posedge clk_i) disable iff (reset_i)
        stall_i |-> (stall_run < 5'd17))
        else $error("stall held for more than 17 cycles");

    assert property (@(posedge clk_i) disable iff (reset_i)
        !is_valid_i |-> !(mem_write_en_i || mem_read_en_i || reg_write_en_i || stall_i))
        else $error("enable active in an invalid cycle");

endmodule

bind thumb_ctrl_top thumb_ctrl_properties thumb_ctrl_properties_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .is_valid_i     (is_valid_o),
    .stall_i        (stall_o),
    .mem_write_en_i (mem_write_en_o),
    .mem_read_en_i  (mem_read_en_o),
    .reg_write_en_i (reg_write_en_o)
);

`default_nettype wire

//--- thumb_ctrl_top.sv
`default_nettype none

module thumb_ctrl_top (
    input  logic                                    clk_i,
    input  logic                                    reset_i,
    input  logic                                    is_valid_i,
    input  logic [thumb_ctrl_pkg::INST_WIDTH-1:0]   instruction_i,
    output logic                                    is_valid_o,
    output logic                                    update_flag_o,
    output logic                                    mem_write_en_o,
    output logic                                    mem_read_en_o,
    output logic                                    reg_write_en_o,
    output logic                                    reg_data_from_mem_o,
    output thumb_ctrl_pkg::alu_src_e                alu_a_sel_o,
    output thumb_ctrl_pkg::alu_src_e                alu_b_sel_o,
    output thumb_ctrl_pkg::alu_op_e                 alu_op_o,
    output logic                                    stall_o,
    output logic                                    reg_addr_2_from_ctrl_o,
    output logic                                    reg_dest_from_ctrl_o,
    output logic                                    reg_3_select_o,
    output logic [thumb_ctrl_pkg::WORD-1:0]         accumulator_imm_o,
    output logic [thumb_ctrl_pkg::ADDR_WIDTH-1:0]   reg_file_addr_o
);

    inst_fields_if fields ();
    ctrl_word_if   word ();
    seq_ctrl_if    seq ();

    inst_class_decode inst_class_decode_i (
        .instruction_i (instruction_i),
        .is_valid_i    (is_valid_i),
        .fields        (fields.src)
    );

    alu_op_decode alu_op_decode_i (
        .fields (fields.dst),
        .word   (word.src)
    );

    // the only stateful block, it owns the outputs during STM and push
    reg_list_sequencer reg_list_sequencer_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .fields  (fields.dst),
        .seq     (seq.src)
    );

    ctrl_output_stage ctrl_output_stage_i (
        .word                   (word.dst),
        .seq                    (seq.dst),
        .is_valid_o             (is_valid_o),
        .update_flag_o          (update_flag_o),
        .mem_write_en_o         (mem_write_en_o),
        .mem_read_en_o          (mem_read_en_o),
        .reg_write_en_o         (reg_write_en_o),
        .reg_data_from_mem_o    (reg_data_from_mem_o),
        .alu_a_sel_o            (alu_a_sel_o),
        .alu_b_sel_o            (alu_b_sel_o),
        .alu_op_o               (alu_op_o),
        .stall_o                (stall_o),
        .reg_addr_2_from_ctrl_o (reg_addr_2_from_ctrl_o),
        .reg_dest_from_ctrl_o   (reg_dest_from_ctrl_o),
        .reg_3_select_o         (reg_3_select_o),
        .accumulator_imm_o      (accumulator_imm_o),
        .reg_file_addr_o        (reg_file_addr_o)
    );

endmodule

`default_nettype wire

//--- ctrl_output_stage.sv
`default_nettype none

module ctrl_output_stage (
    ctrl_word_if.dst                                word,
    seq_ctrl_if.dst                                 seq,
    output logic                                    is_valid_o,
    output logic                                    update_flag_o,
    output logic                                    mem_write_en_o,
    output logic                                    mem_read_en_o,
    output logic                                    reg_write_en_o,
    output logic                                    reg_data_from_mem_o,
    output thumb_ctrl_pkg::alu_src_e                alu_a_sel_o,
    output thumb_ctrl_pkg::alu_src_e                alu_b_sel_o,
    output thumb_ctrl_pkg::alu_op_e                 alu_op_o,
    output logic                                    stall_o,
    output logic                                    reg_addr_2_from_ctrl_o,
    output logic                                    reg_dest_from_ctrl_o,
    output logic                                    reg_3_select_o,
    output logic [thumb_ctrl_pkg::WORD-1:0]         accumulator_imm_o,
    output logic [thumb_ctrl_pkg::ADDR_WIDTH-1:0]   reg_file_addr_o
);
    import thumb_ctrl_pkg::*;

    // the decoder already picks sub for push and add for STM
    assign alu_op_o            = word.alu_op;
    assign alu_a_sel_o         = word.alu_a_sel;
    assign reg_data_from_mem_o = word.data_from_mem;
    assign reg_3_select_o      = word.reg_3_select;
    assign is_valid_o          = word.valid;

    always_comb begin
        update_flag_o = word.update_flag;

        if (seq.active) begin
            mem_write_en_o         = seq.mem_write;
            mem_read_en_o          = 1'b0;
            reg_write_en_o         = seq.reg_write;
            stall_o                = seq.stall;
            reg_addr_2_from_ctrl_o = seq.addr_2_from_ctrl;
            reg_dest_from_ctrl_o   = seq.dest_from_ctrl;
            alu_b_sel_o            = FROM_ACCUMULATOR;
            accumulator_imm_o      = seq.acc_imm;
            reg_file_addr_o        = seq.reg_addr;
        end else begin
            mem_write_en_o         = word.mem_write;
            mem_read_en_o          = word.mem_read;
            reg_write_en_o         = word.reg_write;
            stall_o                = 1'b0;
            reg_addr_2_from_ctrl_o = 1'b0;
            reg_dest_from_ctrl_o   = 1'b0;
            alu_b_sel_o            = word.alu_b_sel;
            accumulator_imm_o      = '0;
            reg_file_addr_o        = '0;
        end

        // an invalid slot must not touch memory, registers or flags
        if (!word.valid) begin
            update_flag_o  = 1'b0;
            mem_write_en_o = 1'b0;
            mem_read_en_o  = 1'b0;
            reg_write_en_o = 1'b0;
            stall_o        = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- reg_list_sequencer.sv
`default_nettype none

module reg_list_sequencer (
    input  logic       clk_i,
    input  logic       reset_i,
    inst_fields_if.dst fields,
    seq_ctrl_if.src    seq
);
    import thumb_ctrl_pkg::*;

    logic [STEP_WIDTH-1:0]     step_q;
    logic [REG_LIST_WIDTH-1:0] hold_mask_q;
    logic [REG_LIST_WIDTH-1:0] pending;
    logic [ADDR_WIDTH-1:0]     next_reg;
    logic                      found;
    logic                      is_push;
    logic [STEP_WIDTH-1:0]     n_regs;
    logic [WORD-1:0]           n_bytes;
    logic [WORD-1:0]           step_bytes;

    assign is_push    = (fields.inst_class == PUSH);
    assign seq.active = is_push || (fields.inst_class == STM);
    assign pending    = fields.reg_list & hold_mask_q;
    assign n_regs     = STEP_WIDTH'($countones(fields.reg_list));
    assign n_bytes    = WORD'(n_regs) * BYTES_PER_REG;
    assign step_bytes = WORD'(step_q) * BYTES_PER_REG;

    // scan from the top so the lowest pending register wins
    always_comb begin
        next_reg = '0;
        found    = 1'b0;
        for (int i = REG_LIST_WIDTH - 1; i >= 0; i--) begin
            if (pending[i]) begin
                next_reg = ADDR_WIDTH'(i);
                found    = 1'b1;
            end
        end
    end

    always_comb begin
        seq.stall            = seq.active && found;
        seq.mem_write        = seq.active && found;
        seq.addr_2_from_ctrl = seq.active && found;
        seq.reg_write        = seq.active && !found;
        seq.dest_from_ctrl   = seq.active && !found && !is_push;

        if (found) begin
            seq.reg_addr = next_reg;
            // push stores from the top of the new frame, STM from the base up
            seq.acc_imm  = is_push ? (n_bytes - step_bytes) : step_bytes;
        end else begin
            // last cycle writes back the base register or SP
            seq.reg_addr = is_push ? SP_REG_NUM : ADDR_WIDTH'(fields.base_reg);
            seq.acc_imm  = n_bytes;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || !seq.stall) begin
            step_q      <= '0;
            hold_mask_q <= '1;
        end else begin
            step_q      <= step_q + 1'b1;
            hold_mask_q <= hold_mask_q & ~(REG_LIST_WIDTH'(1) << next_reg);
        end
    end

endmodule

`default_nettype wire

//--- alu_op_decode.sv
`default_nettype none

module alu_op_decode (
    inst_fields_if.dst fields,
    ctrl_word_if.src   word
);
    import thumb_ctrl_pkg::*;

    always_comb begin
        word.valid         = (fields.inst_class != INVALID);
        word.update_flag   = 1'b0;
        word.mem_write     = 1'b0;
        word.mem_read      = 1'b0;
        word.reg_write     = 1'b0;
        word.data_from_mem = 1'b0;
        word.alu_a_sel     = FROM_REG;
        word.alu_b_sel     = FROM_REG;
        word.alu_op        = ADD;
        word.reg_3_select  = 1'b0;

        case (fields.inst_class)
            SHIFT_IMM: begin
                // nearly every encoding here sets flags and writes a register
                word.update_flag = 1'b1;
                word.reg_write   = 1'b1;
                casez (fields.sub_op)
                    5'b000??: begin
                        word.alu_op    = LSL;
                        word.alu_b_sel = FROM_IMM;
                    end
                    5'b001??: begin
                        word.alu_op    = LSR;
                        word.alu_b_sel = FROM_IMM;
                    end
                    5'b010??: begin
                        word.alu_op    = ASR;
                        word.alu_b_sel = FROM_IMM;
                    end
                    5'b01100: word.alu_op = ADD;
                    5'b01101: word.alu_op = SUB;
                    5'b01110, 5'b110??: begin
                        word.alu_op    = ADD;
                        word.alu_b_sel = FROM_IMM;
                    end
                    5'b01111, 5'b111??: begin
                        word.alu_op    = SUB;
                        word.alu_b_sel = FROM_IMM;
                    end
                    5'b100??: begin
                        // move is zero plus the immediate
                        word.alu_a_sel = FROM_ZERO;
                        word.alu_b_sel = FROM_IMM;
                    end
                    default: begin
                        // compare only leaves the flags behind
                        word.alu_op    = SUB;
                        word.alu_b_sel = FROM_IMM;
                        word.reg_write = 1'b0;
                    end
                endcase
            end
            DATA_PROC: begin
                word.update_flag = 1'b1;
                word.reg_write   = 1'b1;
                case (fields.dp_op)
                    4'd0:  word.alu_op = AND;
                    4'd1:  word.alu_op = XOR;
                    4'd2:  word.alu_op = LSL;
                    4'd3:  word.alu_op = LSR;
                    4'd4:  word.alu_op = ASR;
                    4'd5:  word.alu_op = ADC;
                    4'd6:  word.alu_op = SBC;
                    4'd7:  word.alu_op = ROR;
                    4'd8: begin
                        word.alu_op    = AND;
                        word.reg_write = 1'b0;
                    end
                    4'd9: begin
                        // negate is zero minus the register
                        word.alu_op    = SUB;
                        word.alu_a_sel = FROM_ZERO;
                    end
                    4'd10: begin
                        word.alu_op    = SUB;
                        word.reg_write = 1'b0;
                    end
                    4'd11: word.reg_write = 1'b0;
                    4'd12: word.alu_op = OR;
                    4'd13: word.alu_op = MUL;
                    4'd14: word.alu_op = BIC;
                    default: word.alu_op = MVN;
                endcase
            end
            LS_REG: begin
                word.data_from_mem = 1'b1;
                // the signed loads sit in the store half of the encoding
                if (fields.load_bit || (fields.sub_op[1:0] == 2'b11)) begin
                    word.mem_read  = 1'b1;
                    word.reg_write = 1'b1;
                end else begin
                    word.mem_write    = 1'b1;
                    word.reg_3_select = 1'b1;
                end
            end
            LS_IMM: begin
                word.alu_b_sel     = FROM_IMM;
                word.data_from_mem = 1'b1;
                if (fields.load_bit) begin
                    word.mem_read  = 1'b1;
                    word.reg_write = 1'b1;
                end else begin
                    word.mem_write = 1'b1;
                end
            end
            // push walks the stack downward, STM keeps the default add
            PUSH: word.alu_op = SUB;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- inst_class_decode.sv
`default_nettype none

module inst_class_decode (
    input  logic [thumb_ctrl_pkg::INST_WIDTH-1:0] instruction_i,
    input  logic                                  is_valid_i,
    inst_fields_if.src                            fields
);
    import thumb_ctrl_pkg::*;

    // plain bit slices that every group shares
    assign fields.sub_op   = instruction_i[SUB_OP_HI:SUB_OP_LO];
    assign fields.dp_op    = instruction_i[DP_OP_HI:DP_OP_LO];
    assign fields.load_bit = instruction_i[LOAD_BIT_POS];
    assign fields.base_reg = instruction_i[BASE_HI:BASE_LO];

    always_comb begin
        fields.inst_class = INVALID;
        fields.reg_list   = '0;

        if (is_valid_i) begin
            if (instruction_i[15:14] == 2'b00) begin
                fields.inst_class = SHIFT_IMM;
            end else if (instruction_i[15:10] == 6'b010000) begin
                fields.inst_class = DATA_PROC;
            end else if (instruction_i[15:12] == 4'b0101) begin
                fields.inst_class = LS_REG;
            end else if ((instruction_i[15:13] == 3'b011) ||
                         (instruction_i[15:12] == 4'b1000) ||
                         (instruction_i[15:12] == 4'b1001)) begin
                // word/byte, halfword and SP-relative offsets all land here
                fields.inst_class = LS_IMM;
            end else if (instruction_i[15:9] == 7'b1011010) begin
                fields.inst_class                 = PUSH;
                fields.reg_list[LIST_HI:0]        = instruction_i[LIST_HI:0];
                // the extra push bit stands for the link register
                fields.reg_list[LR_REG_NUM]       = instruction_i[PUSH_LR_POS];
            end else if (instruction_i[15:11] == 5'b11000) begin
                fields.inst_class          = STM;
                fields.reg_list[LIST_HI:0] = instruction_i[LIST_HI:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- seq_ctrl_if.sv
`default_nettype none

interface seq_ctrl_if;
    import thumb_ctrl_pkg::*;

    logic                  active;
    logic                  stall;
    logic                  mem_write;
    logic                  reg_write;
    logic                  addr_2_from_ctrl;
    logic                  dest_from_ctrl;
    logic [ADDR_WIDTH-1:0] reg_addr;
    logic [WORD-1:0]       acc_imm;

    modport src (
        output active, stall, mem_write, reg_write, addr_2_from_ctrl, dest_from_ctrl,
        output reg_addr, acc_imm
    );

    modport dst (
        input active, stall, mem_write, reg_write, addr_2_from_ctrl, dest_from_ctrl,
        input reg_addr, acc_imm
    );

endinterface

`default_nettype wire

//--- ctrl_word_if.sv
`default_nettype none

interface ctrl_word_if;
    import thumb_ctrl_pkg::*;

    logic     valid;
    logic     update_flag;
    logic     mem_write;
    logic     mem_read;
    logic     reg_write;
    logic     data_from_mem;
    alu_src_e alu_a_sel;
    alu_src_e alu_b_sel;
    alu_op_e  alu_op;
    logic     reg_3_select;

    modport src (
        output valid, update_flag, mem_write, mem_read, reg_write, data_from_mem,
        output alu_a_sel, alu_b_sel, alu_op, reg_3_select
    );

    modport dst (
        input valid, update_flag, mem_write, mem_read, reg_write, data_from_mem,
        input alu_a_sel, alu_b_sel, alu_op, reg_3_select
    );

endinterface

`default_nettype wire

//--- inst_fields_if.sv
`default_nettype none

interface inst_fields_if;
    import thumb_ctrl_pkg::*;

    inst_class_e               inst_class;
    logic [4:0]                sub_op;
    logic [3:0]                dp_op;
    logic                      load_bit;
    logic [REG_LIST_WIDTH-1:0] reg_list;
    logic [2:0]                base_reg;

    modport src (
        output inst_class, sub_op, dp_op, load_bit, reg_list, base_reg
    );

    modport dst (
        input inst_class, sub_op, dp_op, load_bit, reg_list, base_reg
    );

endinterface

`default_nettype wire

//--- thumb_ctrl_pkg.sv
`default_nettype none

package thumb_ctrl_pkg;

    // datapath widths
    localparam int unsigned INST_WIDTH     = 16;
    localparam int unsigned WORD           = 32;
    localparam int unsigned ADDR_WIDTH     = 4;
    localparam int unsigned REG_LIST_WIDTH = 16;

    // step counter is wide enough for a full sixteen entry list
    localparam int unsigned STEP_WIDTH = 5;

    // fixed register numbers
    localparam logic [ADDR_WIDTH-1:0] SP_REG_NUM = 4'd13;
    localparam int unsigned           LR_REG_NUM = 14;

    // each listed register moves the address by one word
    localparam logic [WORD-1:0] BYTES_PER_REG = 32'd4;

    // instruction field positions
    localparam int unsigned SUB_OP_HI    = 13;
    localparam int unsigned SUB_OP_LO    = 9;
    localparam int unsigned DP_OP_HI     = 9;
    localparam int unsigned DP_OP_LO     = 6;
    localparam int unsigned LOAD_BIT_POS = 11;
    localparam int unsigned BASE_HI      = 10;
    localparam int unsigned BASE_LO      = 8;
    localparam int unsigned LIST_HI      = 7;
    localparam int unsigned PUSH_LR_POS  = 8;

    typedef enum logic [2:0] {
        SHIFT_IMM,
        DATA_PROC,
        LS_REG,
        LS_IMM,
        PUSH,
        STM,
        INVALID
    } inst_class_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        LSL,
        LSR,
        ASR,
        ADC,
        SBC,
        ROR,
        MUL,
        BIC,
        MVN
    } alu_op_e;

    typedef enum logic [1:0] {
        FROM_REG,
        FROM_IMM,
        FROM_ZERO,
        FROM_ACCUMULATOR
    } alu_src_e;

endpackage

`default_nettype wire
